// ==== src/edma_config.svh ====
// global widths and reset values for the DMA engine, included by every design file
`ifndef EDMA_CONFIG_SVH
`define EDMA_CONFIG_SVH

//##############################
// widths
//##############################

`define EDMA_AW 32                  // address and data width
`define EDMA_PW (2*`EDMA_AW+40)     // emesh packet width, 104 bits

//##############################
// reset values
//##############################

`define EDMA_DEF_CFG 32'h0          // config word after reset, engine off

`endif

// ==== src/emesh_pkg.sv ====
// emesh packet layout shared by register decode, readback replies and DMA requests
`include "edma_config.svh"

package emesh_pkg;

   // transfer size per packet
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,  // 8 bit
      DM_HALF   = 2'b01,  // 16 bit
      DM_WORD   = 2'b10,  // 32 bit
      DM_DOUBLE = 2'b11   // 64 bit
   } emesh_datamode_t;

   // msb first, same order as the wire format
   typedef struct packed {
      logic [`EDMA_AW-1:0] srcaddr;   // return address for reads
      logic [`EDMA_AW-1:0] data;      // write data / read reply
      logic [`EDMA_AW-1:0] dstaddr;   // target address
      logic [4:0]          ctrlmode;  // routing hints, unused here
      emesh_datamode_t     datamode;
      logic                write;     // 1 write, 0 read request
   } emesh_packet_t;

endpackage

// ==== src/edma_pkg.sv ====
// DMA register map, sequencer states and the two views of the config word
`include "edma_config.svh"

package edma_pkg;

   import emesh_pkg::*;

   // register index, dstaddr[6:2]
   typedef enum logic [4:0] {
      CONFIG  = 5'd0,
      STRIDE  = 5'd1,   // [15:0] src step, [31:16] dst step
      COUNT   = 5'd2,
      SRCADDR = 5'd3,
      DSTADDR = 5'd4,
      STATUS  = 5'd5    // [1:0] state, [2] done, [3] irq
   } edma_reg_t;

   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      ACTIVE = 2'd1,
      DONE   = 2'd2
   } edma_state_t;

   // config word, raw for the register bank, decoded for the sequencer
   typedef union packed {
      logic [`EDMA_AW-1:0] raw;
      struct packed {
         logic [`EDMA_AW-8:0] rsvd;       // reads back as written
         emesh_datamode_t     datamode;   // bits 6:5
         logic                irqmode;    // bit 4
         logic                spare;      // bit 3
         logic                chainmode;  // bit 2, kept but no chaining
         logic                mastermode; // bit 1
         logic                dma_en;     // bit 0
      } f;
   } edma_cfg_u;

endpackage

// ==== src/edma_cfg_if.sv ====
// register bank to sequencer link, config values one way and working state back
`timescale 1ns/100ps
`include "edma_config.svh"

interface edma_cfg_if
   import edma_pkg::*;
();

   //##############################
   // register bank -> sequencer
   //##############################
   edma_cfg_u           cfg;         // config word
   logic [`EDMA_AW-1:0] stride;      // packed src/dst steps
   logic [`EDMA_AW-1:0] count;       // programmed element count
   logic [`EDMA_AW-1:0] srcaddr;     // programmed read address
   logic [`EDMA_AW-1:0] dstaddr;     // programmed return address
   logic                clear_done;  // STATUS write strobe

   //##############################
   // sequencer -> register bank
   //##############################
   edma_state_t         state;
   logic [`EDMA_AW-1:0] cnt_cur;     // elements left
   logic [`EDMA_AW-1:0] src_cur;     // next read address
   logic [`EDMA_AW-1:0] dst_cur;     // next return address
   logic                update;      // write back the three above

   modport regs (output cfg, stride, count, srcaddr, dstaddr, clear_done,
                 input  state, cnt_cur, src_cur, dst_cur, update);

   modport ctrl (input  cfg, stride, count, srcaddr, dstaddr, clear_done,
                 output state, cnt_cur, src_cur, dst_cur, update);

endinterface

// ==== src/edma_regs.sv ====
// DMA register bank, packet writes and readback, sequencer write-back, status and irq
`timescale 1ns/100ps
`include "edma_config.svh"

module edma_regs
   import emesh_pkg::*;
   import edma_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          access_in,       // one-cycle config strobe
   input  emesh_packet_t packet_in,
   output logic          reg_access_out,  // readback strobe
   output emesh_packet_t reg_packet_out,
   output logic          irq,
   edma_cfg_if.regs      cfg_if
);

   edma_reg_t           reg_idx;
   logic                reg_wr;
   logic                reg_rd;
   logic                cfg_wr;
   logic                stride_wr;
   logic                count_wr;
   logic                src_wr;
   logic                dst_wr;
   logic                status_wr;
   edma_cfg_u           cfg_q;
   logic [`EDMA_AW-1:0] stride_q;
   logic [`EDMA_AW-1:0] count_q;
   logic [`EDMA_AW-1:0] srcaddr_q;
   logic [`EDMA_AW-1:0] dstaddr_q;
   edma_state_t         state_q;          // state one cycle back, for edges
   logic                done_q;
   logic                done_set;
   logic                start_seen;
   logic [`EDMA_AW-1:0] status_word;
   logic [`EDMA_AW-1:0] rd_data;

   //##############################
   // decode
   //##############################

   assign reg_idx   = edma_reg_t'(packet_in.dstaddr[6:2]);  // word index
   assign reg_wr    = access_in & packet_in.write;
   assign reg_rd    = access_in & ~packet_in.write;
   assign cfg_wr    = reg_wr & (reg_idx == CONFIG);
   assign stride_wr = reg_wr & (reg_idx == STRIDE);
   assign count_wr  = reg_wr & (reg_idx == COUNT);
   assign src_wr    = reg_wr & (reg_idx == SRCADDR);
   assign dst_wr    = reg_wr & (reg_idx == DSTADDR);
   assign status_wr = reg_wr & (reg_idx == STATUS);

   //##############################
   // registers
   //##############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg_q   <= `EDMA_DEF_CFG;
         count_q <= '0;                           // keeps IDLE from starting
      end else begin
         if (cfg_wr)
            cfg_q.raw <= packet_in.data;          // stored raw
         if (count_wr)
            count_q <= packet_in.data;
         else if (cfg_if.update)
            count_q <= cfg_if.cnt_cur;            // write-back, host write wins
      end
   end

   always_ff @(posedge clk) begin
      if (stride_wr)
         stride_q <= packet_in.data;
      if (src_wr)
         srcaddr_q <= packet_in.data;
      else if (cfg_if.update)
         srcaddr_q <= cfg_if.src_cur;
      if (dst_wr)
         dstaddr_q <= packet_in.data;
      else if (cfg_if.update)
         dstaddr_q <= cfg_if.dst_cur;
   end

   //##############################
   // status and irq
   //##############################

   // edges of the sequencer state
   assign done_set   = (cfg_if.state == DONE) & (state_q != DONE);
   assign start_seen = (cfg_if.state == ACTIVE) & (state_q == IDLE);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state_q <= IDLE;
         done_q  <= 1'b0;
      end else begin
         state_q <= cfg_if.state;
         if (cfg_if.clear_done || start_seen)
            done_q <= 1'b0;                       // clear beats a same-cycle set
         else if (done_set)
            done_q <= 1'b1;
      end
   end

   assign irq         = done_q & cfg_q.f.irqmode;
   assign status_word = {{(`EDMA_AW-4){1'b0}}, irq, done_q, cfg_if.state};

   //##############################
   // readback
   //##############################

   always_comb begin
      case (reg_idx)
         CONFIG:  rd_data = cfg_q.raw;
         STRIDE:  rd_data = stride_q;
         COUNT:   rd_data = count_q;
         SRCADDR: rd_data = srcaddr_q;
         DSTADDR: rd_data = dstaddr_q;
         STATUS:  rd_data = status_word;
         default: rd_data = '0;                   // unmapped reads zero
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         reg_access_out <= 1'b0;
      else
         reg_access_out <= reg_rd;                // one cycle after request
   end

   // reply goes back to the requester's return address
   always_ff @(posedge clk) begin
      if (reg_rd) begin
         reg_packet_out.srcaddr  <= packet_in.dstaddr;
         reg_packet_out.data     <= rd_data;
         reg_packet_out.dstaddr  <= packet_in.srcaddr;
         reg_packet_out.ctrlmode <= '0;
         reg_packet_out.datamode <= packet_in.datamode;
         reg_packet_out.write    <= 1'b1;
      end
   end

   //##############################
   // to sequencer
   //##############################

   assign cfg_if.cfg        = cfg_q;
   assign cfg_if.stride     = stride_q;
   assign cfg_if.count      = count_q;
   assign cfg_if.srcaddr    = srcaddr_q;
   assign cfg_if.dstaddr    = dstaddr_q;
   assign cfg_if.clear_done = status_wr;

endmodule

// ==== src/edma_ctrl.sv ====
// DMA sequencer, steps count and addresses and issues emesh read requests under wait
`timescale 1ns/100ps
`include "edma_config.svh"

module edma_ctrl
   import emesh_pkg::*;
   import edma_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   edma_cfg_if.ctrl      cfg_if,
   output logic          access_out,   // request valid, held while wait_in
   output emesh_packet_t packet_out,
   input  logic          wait_in
);

   localparam logic [`EDMA_AW-1:0] CNT_STEP = 1;

   edma_state_t         state;
   logic [`EDMA_AW-1:0] cnt_cur;
   logic [`EDMA_AW-1:0] src_cur;
   logic [`EDMA_AW-1:0] dst_cur;
   logic [`EDMA_AW-1:0] cnt_nxt;
   logic [`EDMA_AW-1:0] src_nxt;
   logic [`EDMA_AW-1:0] dst_nxt;
   logic                update;
   logic                start;
   logic                issue;
   logic                accept;
   logic                last;

   // read request, data and ctrlmode always zero
   function automatic emesh_packet_t build_req(input logic [`EDMA_AW-1:0] rd_addr,
                                               input logic [`EDMA_AW-1:0] ret_addr,
                                               input emesh_datamode_t     mode);
      emesh_packet_t p;
      p.srcaddr  = ret_addr;
      p.data     = '0;
      p.dstaddr  = rd_addr;
      p.ctrlmode = '0;
      p.datamode = mode;
      p.write    = 1'b0;
      return p;
   endfunction

   assign start   = (state == IDLE) & cfg_if.cfg.f.dma_en & (cfg_if.count != '0);
   assign issue   = (state == ACTIVE) & ~access_out;  // first packet only
   assign accept  = access_out & ~wait_in;
   assign cnt_nxt = cnt_cur - CNT_STEP;
   assign last    = (cnt_nxt == '0);
   // low half steps the read side, high half the return side
   assign src_nxt = src_cur + {{(`EDMA_AW-16){1'b0}}, cfg_if.stride[15:0]};
   assign dst_nxt = dst_cur + {{(`EDMA_AW-16){1'b0}}, cfg_if.stride[`EDMA_AW-1:16]};

   //##############################
   // fsm and count
   //##############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state      <= IDLE;
         access_out <= 1'b0;
         update     <= 1'b0;
         cnt_cur    <= '0;
      end else begin
         update <= accept;                        // new values visible with it
         case (state)
            IDLE: if (start) begin
               cnt_cur <= cfg_if.count;
               state   <= ACTIVE;
            end
            ACTIVE: begin
               if (issue)
                  access_out <= 1'b1;
               else if (accept) begin
                  cnt_cur <= cnt_nxt;
                  if (last) begin
                     access_out <= 1'b0;
                     state      <= DONE;
                  end
               end
            end
            DONE: if (!cfg_if.cfg.f.dma_en)
               state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   //##############################
   // addresses and packet
   //##############################

   always_ff @(posedge clk) begin
      if (start) begin
         src_cur <= cfg_if.srcaddr;
         dst_cur <= cfg_if.dstaddr;
      end else if (accept) begin
         src_cur <= src_nxt;
         dst_cur <= dst_nxt;
      end
      if (issue)
         packet_out <= build_req(src_cur, dst_cur, cfg_if.cfg.f.datamode);
      else if (accept && !last)
         packet_out <= build_req(src_nxt, dst_nxt, cfg_if.cfg.f.datamode);  // back to back
   end

   assign cfg_if.state   = state;
   assign cfg_if.cnt_cur = cnt_cur;
   assign cfg_if.src_cur = src_cur;
   assign cfg_if.dst_cur = dst_cur;
   assign cfg_if.update  = update;

endmodule

// ==== src/edma.sv ====
// DMA engine top, register bank plus request sequencer on flat emesh packet ports
`timescale 1ns/100ps
`include "edma_config.svh"

module edma
   import emesh_pkg::*;
(
   input  logic                clk,
   input  logic                nreset,
   input  logic                access_in,       // config write/read strobe
   input  logic [`EDMA_PW-1:0] packet_in,
   output logic                reg_access_out,  // readback reply
   output logic [`EDMA_PW-1:0] reg_packet_out,
   output logic                access_out,      // read requests
   output logic [`EDMA_PW-1:0] packet_out,
   input  logic                wait_in,         // pushback on requests
   output logic                irq
);

   emesh_packet_t pkt_in;
   emesh_packet_t reg_pkt;
   emesh_packet_t req_pkt;

   edma_cfg_if cfg_if ();

   assign pkt_in = emesh_packet_t'(packet_in);

   edma_regs regs0 (
      .clk            (clk),
      .nreset         (nreset),
      .access_in      (access_in),
      .packet_in      (pkt_in),
      .reg_access_out (reg_access_out),
      .reg_packet_out (reg_pkt),
      .irq            (irq),
      .cfg_if         (cfg_if.regs)
   );

   edma_ctrl ctrl0 (
      .clk        (clk),
      .nreset     (nreset),
      .cfg_if     (cfg_if.ctrl),
      .access_out (access_out),
      .packet_out (req_pkt),
      .wait_in    (wait_in)
   );

   assign reg_packet_out = reg_pkt;  // struct back to flat wire format
   assign packet_out     = req_pkt;

endmodule

// ==== bench/edma_sva.sv ====
// request port and irq assertions bound into the DMA top level
`timescale 1ns/100ps
`include "edma_config.svh"

module edma_sva
   import edma_pkg::*;
(
   input logic                clk,
   input logic                nreset,
   input logic                access_out,
   input logic [`EDMA_PW-1:0] packet_out,
   input logic                wait_in,
   input logic                irq,
   input logic                done_flag,   // status bit 2
   input edma_state_t         state        // sequencer state
);

   // a stalled request stays put under emesh pushback
   hold_under_wait: assert property (@(posedge clk) disable iff (!nreset)
      access_out && wait_in |=> access_out && $stable(packet_out))
      else $error("request changed while stalled");

   // irq only with the done flag and low after any ACTIVE cycle
   irq_needs_done: assert property (@(posedge clk) disable iff (!nreset)
      irq |-> done_flag && $past(state) != ACTIVE)
      else $error("irq high without done flag or during a transfer");

   // requests only while a transfer runs
   access_only_active: assert property (@(posedge clk) disable iff (!nreset)
      access_out |-> state == ACTIVE)
      else $error("access_out high outside ACTIVE");

endmodule

bind edma edma_sva sva0 (
   .clk        (clk),
   .nreset     (nreset),
   .access_out (access_out),
   .packet_out (packet_out),
   .wait_in    (wait_in),
   .irq        (irq),
   .done_flag  (regs0.done_q),
   .state      (cfg_if.state)
);

// ==== bench/edma_tb.sv ====
// top-level testbench of the Verilator build that checks DMA readback, requests and irq
`timescale 1ns/100ps
`include "edma_config.svh"

module edma_tb
   import emesh_pkg::*;
   import edma_pkg::*;
();

   logic                clk;
   logic                nreset;
   logic                access_in;
   emesh_packet_t       packet_in;
   logic                reg_access_out;
   emesh_packet_t       reg_packet_out;
   logic                access_out;
   emesh_packet_t       packet_out;
   logic                wait_in;
   logic                irq;
   logic [31:0]         lfsr_state;
   logic [`EDMA_AW-1:0] prog_src;       // programmed read address
   logic [`EDMA_AW-1:0] prog_dst;       // programmed return address
   logic [`EDMA_AW-1:0] prog_stride;
   logic [`EDMA_AW-1:0] prog_count;     // packets expected this transfer
   emesh_datamode_t     prog_mode;
   logic [`EDMA_AW-1:0] seq_base;       // acc_total at transfer start
   logic [`EDMA_AW-1:0] acc_total = '0; // accepted requests over the whole run
   int                  mismatches;
   int                  other_errors;
   int                  req_mismatches = 0;
   int                  req_extra = 0;

   edma dut0 (
      .clk            (clk),
      .nreset         (nreset),
      .access_in      (access_in),
      .packet_in      (packet_in),
      .reg_access_out (reg_access_out),
      .reg_packet_out (reg_packet_out),
      .access_out     (access_out),
      .packet_out     (packet_out),
      .wait_in        (wait_in),
      .irq            (irq)
   );

   always #10 clk = ~clk;   // 20 ns period

   //##############################
   // random source
   //##############################

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois form
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   //##############################
   // reference and checks
   //##############################

   // element n reads src + n*low stride and returns to dst + n*high stride
   function automatic emesh_packet_t expected_req(input logic [`EDMA_AW-1:0] n);
      emesh_packet_t p;
      p.srcaddr  = prog_dst + n * {16'h0, prog_stride[31:16]};
      p.data     = '0;                                          // read request
      p.dstaddr  = prog_src + n * {16'h0, prog_stride[15:0]};
      p.ctrlmode = '0;
      p.datamode = prog_mode;
      p.write    = 1'b0;
      return p;
   endfunction

   task automatic check_packet(input string name, input emesh_packet_t exp,
                               input emesh_packet_t got);
      if (got !== exp) begin
         req_mismatches++;
         $display("mismatch %s expected %h actual %h", name, exp, got);
      end
   endtask

   task automatic check_word(input string name, input logic [`EDMA_AW-1:0] exp,
                             input logic [`EDMA_AW-1:0] got);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s expected %h actual %h", name, exp, got);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s expected %b actual %b", name, exp, got);
      end
   endtask

   // every accepted request against the reference
   always @(negedge clk) begin
      if (nreset && access_out && !wait_in) begin
         if (acc_total - seq_base >= prog_count) begin
            req_extra++;
            $display("request accepted beyond the programmed count");
         end else
            check_packet($sformatf("request %0d", acc_total - seq_base),
                         expected_req(acc_total - seq_base), packet_out);
         acc_total = acc_total + 1;
      end
   end

   //##############################
   // register access
   //##############################

   task automatic reg_write(input logic [4:0] idx, input logic [`EDMA_AW-1:0] val);
      emesh_packet_t p;
      p          = '0;
      p.dstaddr  = {25'h0, idx, 2'b00};
      p.data     = val;
      p.datamode = DM_WORD;
      p.write    = 1'b1;
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= p;
      @(posedge clk);
      access_in <= 1'b0;
   endtask

   // reads from a random return address and checks the reply fields
   task automatic reg_read(input logic [4:0] idx, output logic [`EDMA_AW-1:0] val);
      emesh_packet_t p;
      logic [31:0]   bits;
      int            n;
      p          = '0;
      bits       = take_bits(32);
      p.srcaddr  = bits;
      bits       = take_bits(25);
      p.dstaddr  = {bits[24:0], idx, 2'b00};
      bits       = take_bits(2);
      p.datamode = emesh_datamode_t'(bits[1:0]);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= p;
      @(posedge clk);
      access_in <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!reg_access_out && n < 8) begin
         n++;
         @(negedge clk);
      end
      val = reg_packet_out.data;
      if (!reg_access_out) begin
         other_errors++;
         $display("no readback reply for register index %0d", idx);
      end else begin
         check_bit("reply one cycle after request", 1'b1, n == 0);
         check_bit("reply write bit", 1'b1, reg_packet_out.write);
         check_word("reply dstaddr", p.srcaddr, reg_packet_out.dstaddr);
         check_word("reply datamode", {30'h0, p.datamode}, {30'h0, reg_packet_out.datamode});
      end
   endtask

   //##############################
   // one full transfer
   //##############################

   task automatic run_transfer(input logic stall, input logic irqm);
      edma_cfg_u           cfg;
      logic [31:0]         bits;
      logic [`EDMA_AW-1:0] val;
      emesh_packet_t       last;
      int                  n;
      prog_count  = take_bits(4) + 32'd1;            // 1 to 16
      prog_src    = take_bits(32);
      prog_dst    = take_bits(32);
      prog_stride = take_bits(32);
      bits        = take_bits(2);
      prog_mode   = emesh_datamode_t'(bits[1:0]);
      seq_base    = acc_total;
      reg_write(STRIDE, prog_stride);
      reg_write(COUNT, prog_count);
      reg_write(SRCADDR, prog_src);
      reg_write(DSTADDR, prog_dst);
      cfg              = '0;
      cfg.f.dma_en     = 1'b1;
      cfg.f.mastermode = 1'b1;
      cfg.f.irqmode    = irqm;
      cfg.f.datamode   = prog_mode;
      reg_write(CONFIG, cfg.raw);                     // starts the engine
      n = 0;
      while (acc_total - seq_base < prog_count && n < 1000) begin
         @(posedge clk);
         bits = take_bits(1);
         wait_in <= stall & bits[0];                  // about half the cycles stalled
         n++;
      end
      wait_in <= 1'b0;
      if (acc_total - seq_base < prog_count) begin
         other_errors++;
         $display("transfer timed out after %0d requests", acc_total - seq_base);
      end
      n = 0;
      reg_read(STATUS, val);
      while (val[1:0] != DONE && n < 20) begin
         n++;
         reg_read(STATUS, val);
      end
      if (val[1:0] != DONE) begin
         other_errors++;
         $display("engine never reached the DONE state");
      end
      check_bit("done flag", 1'b1, val[2]);
      check_bit("status irq", irqm, val[3]);
      check_bit("irq pin", irqm, irq);
      last = expected_req(prog_count);               // addresses after the last step
      reg_read(COUNT, val);
      check_word("count write-back", '0, val);
      reg_read(SRCADDR, val);
      check_word("srcaddr write-back", last.dstaddr, val);
      reg_read(DSTADDR, val);
      check_word("dstaddr write-back", last.srcaddr, val);
      check_word("accepted requests", prog_count, acc_total - seq_base);
      reg_write(STATUS, '0);                          // clears done and irq
      reg_read(STATUS, val);
      check_bit("done flag after clear", 1'b0, val[2]);
      check_bit("irq after clear", 1'b0, irq);
      cfg.f.dma_en = 1'b0;
      reg_write(CONFIG, cfg.raw);
      reg_read(STATUS, val);
      check_word("status after disable", '0, val);   // idle with flags low
   endtask

   //##############################
   // main sequence
   //##############################

   initial begin
      logic [`EDMA_AW-1:0] vals [5];
      logic [`EDMA_AW-1:0] val;
      int                  total;
      clk          = 1'b0;
      nreset       = 1'b0;
      access_in    = 1'b0;
      packet_in    = '0;
      wait_in      = 1'b0;
      lfsr_state   = 32'hac17ef10;
      prog_src     = '0;
      prog_dst     = '0;
      prog_stride  = '0;
      prog_count   = '0;                              // no requests expected yet
      prog_mode    = DM_BYTE;
      seq_base     = '0;
      mismatches   = 0;
      other_errors = 0;
      repeat (5) @(posedge clk);
      nreset <= 1'b1;
      @(negedge clk);
      check_bit("access_out after reset", 1'b0, access_out);
      check_bit("reg_access_out after reset", 1'b0, reg_access_out);
      check_bit("irq after reset", 1'b0, irq);
      reg_read(STATUS, val);
      check_word("status after reset", '0, val);
      reg_read(CONFIG, val);
      check_word("config after reset", `EDMA_DEF_CFG, val);
      // indices 0 to 4 are CONFIG, STRIDE, COUNT, SRCADDR, DSTADDR
      for (int i = 0; i < 5; i++) begin
         vals[i] = take_bits(32);
         if (i == 0)
            vals[i][0] = 1'b0;                        // dma_en stays clear
         reg_write(5'(i), vals[i]);
      end
      for (int i = 0; i < 5; i++) begin
         reg_read(5'(i), val);
         check_word($sformatf("readback index %0d", i), vals[i], val);
      end
      reg_read(5'd7, val);
      check_word("unmapped index 7", '0, val);
      reg_read(5'd31, val);
      check_word("unmapped index 31", '0, val);
      run_transfer(1'b0, 1'b1);
      run_transfer(1'b1, 1'b0);
      run_transfer(1'b1, 1'b1);
      total = mismatches + other_errors + req_mismatches + req_extra;
      $display("errors: %0d register, %0d request mismatches, %0d extra requests, %0d other",
               mismatches, req_mismatches, req_extra, other_errors);
      if (total == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== edma.f ====
+incdir+src
src/emesh_pkg.sv
src/edma_pkg.sv
src/edma_cfg_if.sv
src/edma_regs.sv
src/edma_ctrl.sv
src/edma.sv
bench/edma_sva.sv
bench/edma_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the DMA engine testbench

.PHONY: all lint clean

all: obj_dir/Vedma_tb
	./obj_dir/Vedma_tb > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
	cat sim.log
	! grep -q ">>> FAIL" sim.log

obj_dir/Vedma_tb: edma.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert --top-module edma_tb -f edma.f

lint:
	verilator --lint-only --timing --assert --top-module edma -f edma.f
	verilator --lint-only --timing --assert --top-module edma_tb -f edma.f

clean:
	rm -rf obj_dir sim.log
